// File: Makefile
VERILATOR := verilator
VFLAGS := --binary --timing -Wno-fatal
TOP := tb_vdp_mem
FILELIST := src.f
OBJ_DIR := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/mem_controller.sv
// client side of the vram controller
// request capture and strobes towards the sequencer
// write data steering and byte mask generation
// read half select, read data capture and the fail flag
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

module mem_controller import vdp_mem_pkg::*; (
  input logic clk,
  input logic resetn,
  input logic read, // request strobes, one cycle
  input logic write,
  input logic refresh,
  input logic [`MEM_ADDR_W-1:0] addr, // byte address
  input mem_width_t width, // write width
  input logic [7:0] din8,
  input logic [15:0] din16,
  input logic [31:0] din32,
  output logic [15:0] dout16, // half selected by addr[1] of the read
  output logic [31:0] dout32, // whole word of the last read
  output logic busy,
  output logic fail, // sticky, read ended without data
  sdram_req_if.ctrl bus
);

  logic accept; // strobe seen while idle
  logic rd_q; // strobes towards the sequencer
  logic wr_q;
  logic ref_q;
  logic [`MEM_ADDR_W-3:0] waddr_q;
  mem_word_u wdata_nxt;
  mem_word_u wdata_q;
  logic [3:0] wmask_nxt;
  logic [3:0] wmask_q;
  logic half_sel; // addr[1] of the read in flight
  logic rd_pending; // a read is in flight
  logic got_data; // data_ready seen for it
  logic seq_busy_q; // sequencer busy, one cycle late
  logic seq_done; // falling edge of sequencer busy

  // the strobe cycle itself is covered, the sequencer raises busy one later
  assign busy = bus.busy | rd_q | wr_q | ref_q;
  assign accept = ~busy & (read | write | refresh);
  assign seq_done = seq_busy_q & ~bus.busy;

  // replicate the write data and enable only the addressed bytes
  always_comb begin
    wdata_nxt.word = din32;
    wmask_nxt = 4'b0000;
    case (width)
      WIDTH_8: begin
        wdata_nxt.word = {4{din8}};
        wmask_nxt = 4'b0001 << addr[1:0];
      end
      WIDTH_16: begin
        wdata_nxt.half = {2{din16}};
        wmask_nxt = addr[1] ? 4'b1100 : 4'b0011;
      end
      WIDTH_32: begin
        wdata_nxt.word = din32;
        wmask_nxt = 4'b1111;
      end
      default: begin
        wmask_nxt = 4'b0000; // WIDTH_NONE, nothing is written
      end
    endcase
  end

  // strobes and read bookkeeping
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
      ref_q <= 1'b0;
      rd_pending <= 1'b0;
      got_data <= 1'b0;
      seq_busy_q <= 1'b1; // sequencer comes out of reset busy
      fail <= 1'b0;
    end else begin
      rd_q <= accept & read; // read wins if several strobes
      wr_q <= accept & ~read & write;
      ref_q <= accept & ~read & ~write & refresh;
      seq_busy_q <= bus.busy;

      if (bus.data_ready)
        got_data <= 1'b1;

      // read finished without a result
      if (seq_done && rd_pending && !got_data)
        fail <= 1'b1;
      if (seq_done)
        rd_pending <= 1'b0;

      // new request may start in the cycle the last one ended
      if (accept) begin
        rd_pending <= read;
        got_data <= 1'b0;
      end
    end
  end

  // request payload, held stable while the sequencer works
  always_ff @(posedge clk) begin
    if (accept) begin
      waddr_q <= addr[`MEM_ADDR_W-1:2]; // drop byte offset
      wdata_q <= wdata_nxt;
      wmask_q <= wmask_nxt;
      half_sel <= addr[1];
    end
  end

  // read result, held until the next read completes
  always_ff @(posedge clk) begin
    if (bus.data_ready) begin
      dout32 <= bus.rdata.word;
      dout16 <= bus.rdata.half[half_sel];
    end
  end

  assign bus.rd = rd_q;
  assign bus.wr = wr_q;
  assign bus.refresh = ref_q;
  assign bus.waddr = waddr_q;
  assign bus.wdata = wdata_q;
  assign bus.wmask = wmask_q;

endmodule

// File: hdl/sdram.sv
// sdram command sequencer
// power-up walk: wait, precharge all, two refreshes, load mode
// single read or write with auto precharge, client-requested refresh
// dq drive during write and registered read capture
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

module sdram import vdp_mem_pkg::*; (
  input logic clk,
  input logic resetn,
  sdram_req_if.seq bus,
  inout wire [31:0] sdram_dq,
  output logic [`SDRAM_ROW_W-1:0] sdram_addr,
  output logic [`SDRAM_BA_W-1:0] sdram_ba,
  output logic sdram_cs_n,
  output logic sdram_we_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_clk,
  output logic sdram_cke,
  output logic [3:0] sdram_dqm
);

  localparam logic [`SDRAM_ROW_W-1:0] ADDR_A10 = 1 << 10; // all banks / auto precharge

  enum logic [2:0] {
    ST_INIT_WAIT, // power-up wait
    ST_INIT_PRE, // precharge all issued
    ST_INIT_REF, // init refreshes
    ST_INIT_MODE, // mode register loaded
    ST_IDLE,
    ST_ACT, // row open, waiting t_rcd
    ST_RD, // waiting cas latency
    ST_RECOVER // precharge or refresh recovery
  } state;

  logic [15:0] cnt; // cycles left in the current state
  logic cnt_zero;
  sdram_cmd_t cmd; // registered command on the pins
  logic op_write; // operation in flight is a write
  logic ref_second; // first init refresh done
  logic dq_oe;
  logic [31:0] dq_out;
  mem_word_u rdata_q;
  logic busy_q;
  logic ready_q;
  logic enabled_q;
  logic [`SDRAM_BA_W-1:0] bank;
  logic [`SDRAM_ROW_W-1:0] row;
  logic [`SDRAM_COL_W-1:0] col;
  logic issue_rw; // read or write goes out next cycle
  logic capture; // read data on dq this cycle

  // word address is {bank, row, col}
  assign bank = bus.waddr[`SDRAM_COL_W+`SDRAM_ROW_W +: `SDRAM_BA_W];
  assign row = bus.waddr[`SDRAM_COL_W +: `SDRAM_ROW_W];
  assign col = bus.waddr[0 +: `SDRAM_COL_W];

  assign cnt_zero = (cnt == 16'd0);
  assign issue_rw = (state == ST_ACT) && cnt_zero;
  assign capture = (state == ST_RD) && cnt_zero;

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
  assign sdram_clk = ~clk; // sdram samples mid-cycle
  assign sdram_cke = 1'b1; // no power-down modes
  assign sdram_dq = dq_oe ? dq_out : 'z;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= ST_INIT_WAIT;
      cnt <= 16'(`SDRAM_T_INIT - 1);
      cmd <= CMD_NOP;
      sdram_addr <= '0;
      sdram_ba <= '0;
      sdram_dqm <= 4'b0000;
      dq_oe <= 1'b0;
      op_write <= 1'b0;
      ref_second <= 1'b0;
      busy_q <= 1'b1; // busy until init completes
      ready_q <= 1'b0;
      enabled_q <= 1'b0;
    end else begin
      cmd <= CMD_NOP; // one-cycle commands
      dq_oe <= 1'b0;
      sdram_dqm <= 4'b0000; // reads always take all bytes
      ready_q <= 1'b0;
      if (!cnt_zero)
        cnt <= cnt - 16'd1;

      case (state)
        ST_INIT_WAIT: begin
          if (cnt_zero) begin
            cmd <= CMD_PRECHARGE;
            sdram_addr <= ADDR_A10; // all banks
            state <= ST_INIT_PRE;
            cnt <= 16'(`SDRAM_T_RP - 1);
          end
        end
        ST_INIT_PRE: begin
          if (cnt_zero) begin
            cmd <= CMD_REFRESH;
            state <= ST_INIT_REF;
            cnt <= 16'(`SDRAM_T_RC - 1);
          end
        end
        ST_INIT_REF: begin
          if (cnt_zero && !ref_second) begin
            cmd <= CMD_REFRESH;
            ref_second <= 1'b1;
            cnt <= 16'(`SDRAM_T_RC - 1);
          end else if (cnt_zero) begin
            cmd <= CMD_LOAD_MODE;
            sdram_addr <= `SDRAM_MODE;
            sdram_ba <= '0;
            state <= ST_INIT_MODE;
            cnt <= 16'(`SDRAM_T_RP - 1); // covers t_mrd
          end
        end
        ST_INIT_MODE: begin
          if (cnt_zero) begin
            enabled_q <= 1'b1;
            busy_q <= 1'b0;
            state <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (bus.rd || bus.wr) begin
            cmd <= CMD_ACTIVE; // open the row
            sdram_addr <= row;
            sdram_ba <= bank;
            op_write <= bus.wr;
            busy_q <= 1'b1;
            state <= ST_ACT;
            cnt <= 16'(`SDRAM_T_RCD - 1);
          end else if (bus.refresh) begin
            cmd <= CMD_REFRESH;
            busy_q <= 1'b1;
            state <= ST_RECOVER;
            cnt <= 16'(`SDRAM_T_RC - 1);
          end
        end
        ST_ACT: begin
          if (cnt_zero) begin
            // column with a10 set, auto precharge
            sdram_addr <= ADDR_A10 | {{(`SDRAM_ROW_W-`SDRAM_COL_W){1'b0}}, col};
            if (op_write) begin
              cmd <= CMD_WRITE;
              dq_oe <= 1'b1;
              sdram_dqm <= ~bus.wmask; // dqm high masks the byte
              state <= ST_RECOVER;
              cnt <= 16'(`SDRAM_T_WR + `SDRAM_T_RP - 1);
            end else begin
              cmd <= CMD_READ;
              state <= ST_RD;
              cnt <= 16'(`SDRAM_CAS);
            end
          end
        end
        ST_RD: begin
          if (cnt_zero) begin
            ready_q <= 1'b1; // rdata_q loads on this edge
            state <= ST_RECOVER;
            cnt <= 16'(`SDRAM_T_RP - 1);
          end
        end
        ST_RECOVER: begin
          if (cnt_zero) begin
            busy_q <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // data path, write word out and read word in
  always_ff @(posedge clk) begin
    if (issue_rw && op_write)
      dq_out <= bus.wdata.word;
    if (capture)
      rdata_q.word <= sdram_dq;
  end

  assign bus.rdata = rdata_q;
  assign bus.busy = busy_q;
  assign bus.data_ready = ready_q;
  assign bus.enabled = enabled_q;

endmodule

// File: hdl/sdram_req_if.sv
// request and result signals between the client-side controller
// and the sdram sequencer, with one modport per side
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

interface sdram_req_if import vdp_mem_pkg::*; ();

  logic [`MEM_ADDR_W-3:0] waddr; // sdram word address {bank, row, col}
  logic rd; // one-cycle strobes, only while busy is low
  logic wr;
  logic refresh;
  mem_word_u wdata; // write data, already replicated across the word
  logic [3:0] wmask; // high = byte is written

  mem_word_u rdata; // valid with data_ready
  logic busy; // high from the cycle after a strobe until recovery ends
  logic data_ready; // one-cycle pulse
  logic enabled; // init sequence finished

  modport ctrl (
    output waddr, rd, wr, refresh, wdata, wmask,
    input rdata, busy, data_ready, enabled
  );

  modport seq (
    input waddr, rd, wr, refresh, wdata, wmask,
    output rdata, busy, data_ready, enabled
  );

endinterface

// File: hdl/vdp_mem_cfg.svh
// address widths of the vram controller
// sdram timing in clk cycles and the mode register value
`ifndef VDP_MEM_CFG_SVH
`define VDP_MEM_CFG_SVH

// client side, byte address into 8 MB
`define MEM_ADDR_W 23

// sdram geometry, word address is {bank, row, col}
`define SDRAM_ROW_W 11
`define SDRAM_COL_W 8
`define SDRAM_BA_W 2

// timing, all in clk cycles
`define SDRAM_T_INIT 1000 // power-up wait before the first command
`define SDRAM_T_RP 2 // precharge period
`define SDRAM_T_RCD 2 // active to read or write
`define SDRAM_CAS 2 // cas latency, must agree with SDRAM_MODE
`define SDRAM_T_WR 2 // write recovery before auto precharge
`define SDRAM_T_RC 6 // refresh to next command

// write burst on, cas 2, sequential, burst length 1
`define SDRAM_MODE 11'b000_0_00_010_0_000

`endif

// File: hdl/vdp_mem_pkg.sv
// shared types of the vram controller
// access width code, sdram command encoding, sdram data word
package vdp_mem_pkg;

  // width code as driven by the client
  typedef enum logic [1:0] {
    WIDTH_8 = 2'b00,
    WIDTH_16 = 2'b01,
    WIDTH_32 = 2'b10,
    WIDTH_NONE = 2'b11 // no bytes written
  } mem_width_t;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE = 4'b0011,
    CMD_WRITE = 4'b0100,
    CMD_READ = 4'b0101,
    CMD_NOP = 4'b0111
  } sdram_cmd_t;

  // one sdram word, taken whole or as two halves
  typedef union packed {
    logic [31:0] word;
    logic [1:0][15:0] half; // half[0] is bits 15:0
  } mem_word_u;

endpackage

// File: hdl/vdp_mem_top.sv
// top level of the vram controller
// client controller and sdram sequencer joined by the request interface
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

module vdp_mem_top import vdp_mem_pkg::*; (
  input logic clk,
  input logic resetn,
  input logic read,
  input logic write,
  input logic refresh,
  input logic [`MEM_ADDR_W-1:0] addr,
  input mem_width_t width,
  input logic [7:0] din8,
  input logic [15:0] din16,
  input logic [31:0] din32,
  output logic [15:0] dout16,
  output logic [31:0] dout32,
  output logic busy,
  output logic enabled,
  output logic fail,
  inout wire [31:0] sdram_dq,
  output logic [`SDRAM_ROW_W-1:0] sdram_addr,
  output logic [`SDRAM_BA_W-1:0] sdram_ba,
  output logic sdram_cs_n,
  output logic sdram_we_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_clk,
  output logic sdram_cke,
  output logic [3:0] sdram_dqm
);

  sdram_req_if bus ();

  mem_controller i_ctrl (
    .clk(clk),
    .resetn(resetn),
    .read(read),
    .write(write),
    .refresh(refresh),
    .addr(addr),
    .width(width),
    .din8(din8),
    .din16(din16),
    .din32(din32),
    .dout16(dout16),
    .dout32(dout32),
    .busy(busy),
    .fail(fail),
    .bus(bus.ctrl)
  );

  sdram i_sdram (
    .clk(clk),
    .resetn(resetn),
    .bus(bus.seq),
    .sdram_dq(sdram_dq),
    .sdram_addr(sdram_addr),
    .sdram_ba(sdram_ba),
    .sdram_cs_n(sdram_cs_n),
    .sdram_we_n(sdram_we_n),
    .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n),
    .sdram_clk(sdram_clk),
    .sdram_cke(sdram_cke),
    .sdram_dqm(sdram_dqm)
  );

  assign enabled = bus.enabled; // init done, straight from the sequencer

endmodule

// File: sim/sdram_model.sv
// behavioural 32-bit sdram for simulation
// command decoder with open-row tracking per bank
// byte masked writes, reads with SDRAM_CAS latency, sticky protocol error flag
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

module sdram_model import vdp_mem_pkg::*; (
  input logic clk, // sdram_clk from the controller
  input logic cke,
  input logic cs_n,
  input logic ras_n,
  input logic cas_n,
  input logic we_n,
  input logic [`SDRAM_BA_W-1:0] ba,
  input logic [`SDRAM_ROW_W-1:0] addr,
  input logic [3:0] dqm, // high masks the byte
  inout wire [31:0] dq,
  output logic cmd_error // sticky, illegal command seen
);

  localparam int WA_W = `SDRAM_BA_W + `SDRAM_ROW_W + `SDRAM_COL_W;
  localparam int BANKS = 1 << `SDRAM_BA_W;

  logic [31:0] mem [logic [WA_W-1:0]]; // only written words are stored
  logic [`SDRAM_ROW_W-1:0] open_row [BANKS];
  logic [BANKS-1:0] row_open = '0;
  logic [WA_W-1:0] rd_addr [`SDRAM_CAS]; // read latency pipeline
  logic [`SDRAM_CAS-1:0] rd_valid = '0;
  logic out_en = 1'b0; // model drives dq
  logic [31:0] out_word;
  logic mode_set = 1'b0; // mode register loaded with the expected value
  int cycles = 0;
  sdram_cmd_t cmd;
  logic [WA_W-1:0] wa; // word address {bank, row, col}

  initial cmd_error = 1'b0;

  assign cmd = cs_n ? CMD_NOP : sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
  assign wa = {ba, open_row[ba], addr[`SDRAM_COL_W-1:0]};
  assign dq = out_en ? out_word : 'z;

  // unwritten words read back a pattern of their whole address
  function automatic logic [31:0] stored_word(input logic [WA_W-1:0] a);
    if (mem.exists(a))
      return mem[a];
    return 32'h5ca1_0000 ^ {{(32-WA_W){1'b0}}, a} ^ {a[10:0], 21'd0};
  endfunction

  always @(posedge clk) begin
    logic [31:0] word;
    if (cke)
      cycles <= cycles + 1;
    for (int i = `SDRAM_CAS - 1; i > 0; i--) begin // shift read pipe
      rd_valid[i] <= rd_valid[i-1];
      rd_addr[i] <= rd_addr[i-1];
    end
    rd_valid[0] <= 1'b0;
    out_en <= rd_valid[`SDRAM_CAS-1]; // data held for one clock
    if (rd_valid[`SDRAM_CAS-1])
      out_word <= stored_word(rd_addr[`SDRAM_CAS-1]);

    if (cmd != CMD_NOP && cycles < `SDRAM_T_INIT)
      cmd_error <= 1'b1; // command inside power-up wait
    case (cmd)
      CMD_ACTIVE: begin
        if (row_open[ba])
          cmd_error <= 1'b1; // bank already open
        row_open[ba] <= 1'b1;
        open_row[ba] <= addr;
      end
      CMD_READ, CMD_WRITE: begin
        if (!row_open[ba] || !mode_set)
          cmd_error <= 1'b1;
        if (addr[10])
          row_open[ba] <= 1'b0; // auto precharge
        if (cmd == CMD_READ) begin
          rd_valid[0] <= 1'b1;
          rd_addr[0] <= wa;
        end else begin
          word = stored_word(wa);
          for (int i = 0; i < 4; i++)
            if (!dqm[i])
              word[8*i +: 8] = dq[8*i +: 8];
          mem[wa] = word;
        end
      end
      CMD_PRECHARGE: begin
        if (addr[10])
          row_open <= '0; // all banks
        else
          row_open[ba] <= 1'b0;
      end
      CMD_REFRESH: begin
        if (row_open != '0)
          cmd_error <= 1'b1; // refresh needs all banks idle
      end
      CMD_LOAD_MODE: mode_set <= (addr == `SDRAM_MODE);
      default: ;
    endcase
  end

endmodule

// File: sim/tb_vdp_mem.sv
// testbench for the vram controller with a behavioural sdram
// directed and random requests against a shadow memory reference
// read results are compared on each falling edge of busy
`timescale 1ns/100ps
`include "vdp_mem_cfg.svh"

module tb_vdp_mem import vdp_mem_pkg::*; ();

  localparam int TIMEOUT = 64; // cycles for one request
  localparam int INIT_TIMEOUT = `SDRAM_T_INIT + 200;

  logic clk;
  logic resetn;
  logic read;
  logic write;
  logic refresh;
  logic [`MEM_ADDR_W-1:0] addr;
  mem_width_t width;
  logic [7:0] din8;
  logic [15:0] din16;
  logic [31:0] din32;
  wire [15:0] dout16;
  wire [31:0] dout32;
  wire busy;
  wire enabled;
  wire fail;
  wire [31:0] sdram_dq;
  wire [`SDRAM_ROW_W-1:0] sdram_addr;
  wire [`SDRAM_BA_W-1:0] sdram_ba;
  wire sdram_cs_n;
  wire sdram_we_n;
  wire sdram_ras_n;
  wire sdram_cas_n;
  wire sdram_clk;
  wire sdram_cke;
  wire [3:0] sdram_dqm;
  wire cmd_error;

  logic [31:0] shadow [int]; // reference memory, keyed by word address
  logic [31:0] exp32_q[$]; // expected results of issued reads
  logic [15:0] exp16_q[$];
  logic busy_prev = 1'b0;
  logic [31:0] rng = 32'h8958_ca92;
  int errors = 0;
  int checks = 0;

  vdp_mem_top i_dut (
    .clk(clk), .resetn(resetn), .read(read), .write(write), .refresh(refresh),
    .addr(addr), .width(width), .din8(din8), .din16(din16), .din32(din32),
    .dout16(dout16), .dout32(dout32), .busy(busy), .enabled(enabled), .fail(fail),
    .sdram_dq(sdram_dq), .sdram_addr(sdram_addr), .sdram_ba(sdram_ba),
    .sdram_cs_n(sdram_cs_n), .sdram_we_n(sdram_we_n), .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n), .sdram_clk(sdram_clk), .sdram_cke(sdram_cke),
    .sdram_dqm(sdram_dqm)
  );

  sdram_model i_sdram_model (
    .clk(sdram_clk), .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n),
    .cas_n(sdram_cas_n), .we_n(sdram_we_n), .ba(sdram_ba), .addr(sdram_addr),
    .dqm(sdram_dqm), .dq(sdram_dq), .cmd_error(cmd_error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // merge one client write into the stored word, byte by byte
  function automatic logic [31:0] expected_word(input logic [31:0] old,
      input logic [1:0] offs, input mem_width_t w, input logic [31:0] data);
    logic [31:0] merged;
    merged = old;
    for (int i = 0; i < 4; i++) begin
      if (w == WIDTH_32)
        merged[8*i +: 8] = data[8*i +: 8];
      else if (w == WIDTH_16 && (i / 2) == int'(offs[1]))
        merged[8*i +: 8] = data[8*(i%2) +: 8]; // din16 in both halves
      else if (w == WIDTH_8 && i == int'(offs))
        merged[8*i +: 8] = data[7:0];
    end
    return merged;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finish_report();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("Timeout: busy did not fall within %0d cycles", TIMEOUT);
      errors++;
      finish_report();
    end
  endtask

  task automatic wait_enabled();
    int n;
    n = 0;
    @(negedge clk);
    while (!enabled && n < INIT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!enabled) begin
      $display("Timeout: initialisation did not finish, enabled stayed low");
      errors++;
      finish_report();
    end
  endtask

  // one strobe cycle, then wait for the request to end
  task automatic issue_request(input logic rd, input logic wr, input logic rf,
      input logic [`MEM_ADDR_W-1:0] a, input mem_width_t w, input logic [31:0] data);
    @(posedge clk);
    read <= rd;
    write <= wr;
    refresh <= rf;
    addr <= a;
    width <= w;
    din8 <= data[7:0];
    din16 <= data[15:0];
    din32 <= data;
    @(posedge clk);
    read <= 1'b0;
    write <= 1'b0;
    refresh <= 1'b0;
    wait_idle();
  endtask

  task automatic write_and_track(input logic [`MEM_ADDR_W-1:0] a, input mem_width_t w,
      input logic [31:0] data);
    int key;
    key = int'(a[`MEM_ADDR_W-1:2]);
    shadow[key] = expected_word(shadow.exists(key) ? shadow[key] : 32'd0, a[1:0], w, data);
    issue_request(1'b0, 1'b1, 1'b0, a, w, data);
  endtask

  task automatic read_and_check(input logic [`MEM_ADDR_W-1:0] a);
    logic [31:0] word;
    word = shadow[int'(a[`MEM_ADDR_W-1:2])];
    @(posedge clk); // queued after the previous busy fall was compared
    exp32_q.push_back(word);
    exp16_q.push_back(a[1] ? word[31:16] : word[15:0]); // half picked by addr[1]
    issue_request(1'b1, 1'b0, 1'b0, a, WIDTH_NONE, 32'd0);
  endtask

  // compare results as each request ends
  always @(negedge clk) begin
    logic [31:0] e32;
    logic [15:0] e16;
    if (resetn && busy_prev && !busy) begin
      check_value("fail", 32'(fail), 32'd0);
      check_value("cmd_error", 32'(cmd_error), 32'd0);
      if (exp32_q.size() > 0) begin
        e32 = exp32_q.pop_front();
        e16 = exp16_q.pop_front();
        check_value("dout32", dout32, e32);
        check_value("dout16", 32'(dout16), 32'(e16));
      end
    end
    busy_prev <= busy;
  end

  initial begin
    logic [31:0] r;
    logic [`MEM_ADDR_W-1:0] a;
    resetn <= 1'b0;
    read <= 1'b0;
    write <= 1'b0;
    refresh <= 1'b0;
    addr <= '0;
    width <= WIDTH_32;
    din8 <= 8'd0;
    din16 <= 16'd0;
    din32 <= 32'd0;
    @(negedge clk); // state inside reset
    check_value("busy", 32'(busy), 32'd1);
    check_value("fail", 32'(fail), 32'd0);
    check_value("enabled", 32'(enabled), 32'd0);
    check_value("sdram_cmd", 32'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n}),
        32'(CMD_NOP));
    check_value("sdram_cke", 32'(sdram_cke), 32'd1);
    repeat (3) @(posedge clk);
    resetn <= 1'b1; // low over four rising edges
    wait_enabled();
    check_value("busy", 32'(busy), 32'd0);

    write_and_track(23'h000100, WIDTH_32, 32'h1234_5678); // full word, both halves
    read_and_check(23'h000100);
    read_and_check(23'h000102);
    write_and_track(23'h7f_fe04, WIDTH_32, 32'hcafe_f00d); // last bank, high row
    read_and_check(23'h7f_fe06);

    write_and_track(23'h000200, WIDTH_32, 32'ha5a5_5a5a);
    for (int i = 0; i < 4; i++) begin // each byte lane
      rng = xorshift32(rng);
      write_and_track(23'h000200 + 23'(i), WIDTH_8, rng);
      read_and_check(23'h000200);
    end
    for (int i = 0; i < 2; i++) begin // each half
      rng = xorshift32(rng);
      write_and_track(23'h000200 + 23'(2 * i), WIDTH_16, rng);
      read_and_check(23'h000202);
    end

    write_and_track(23'h000204, WIDTH_32, 32'h0bad_beef);
    write_and_track(23'h000200, WIDTH_NONE, 32'hffff_ffff); // no bytes enabled
    read_and_check(23'h000200);
    shadow[int'(23'h000300 >> 2)] = 32'h1357_9bdf;
    @(posedge clk);
    write <= 1'b1;
    addr <= 23'h000300;
    width <= WIDTH_32;
    din32 <= 32'h1357_9bdf;
    @(posedge clk); // accepted here
    addr <= 23'h000204;
    din32 <= 32'hdead_dead; // strobe held into the busy cycle
    @(negedge clk);
    check_value("busy", 32'(busy), 32'd1);
    @(posedge clk);
    write <= 1'b0;
    wait_idle();
    read_and_check(23'h000300);
    read_and_check(23'h000204);

    write_and_track(23'h000400, WIDTH_32, 32'h2468_ace0);
    issue_request(1'b0, 1'b0, 1'b1, '0, WIDTH_NONE, 32'd0); // refresh
    read_and_check(23'h000400);
    read_and_check(23'h000100);

    for (int i = 0; i < 16; i++) begin // fill the random window
      rng = xorshift32(rng);
      write_and_track(23'h001000 + 23'(4 * i), WIDTH_32, rng);
    end
    for (int n = 0; n < 60; n++) begin
      rng = xorshift32(rng);
      r = rng;
      a = 23'h001000 | 23'(r[5:0]);
      if (r[10:8] == 3'd7) begin
        issue_request(1'b0, 1'b0, 1'b1, '0, WIDTH_NONE, 32'd0);
      end else if (r[6]) begin
        read_and_check(a);
      end else begin
        rng = xorshift32(rng);
        write_and_track(a, mem_width_t'(r[13:12]), rng); // none included
      end
    end

    @(posedge clk); // last busy-fall compare has run by now
    check_value("fail", 32'(fail), 32'd0);
    if (exp32_q.size() != 0) begin
      $display("Error: %0d read results were never compared", exp32_q.size());
      errors++;
    end
    finish_report();
  end

endmodule

// File: src.f
+incdir+hdl
hdl/vdp_mem_pkg.sv
hdl/sdram_req_if.sv
hdl/mem_controller.sv
hdl/sdram.sv
hdl/vdp_mem_top.sv
sim/sdram_model.sv
sim/tb_vdp_mem.sv
